//--- hw/cart_params.svh
`ifndef CART_PARAMS_SVH
`define CART_PARAMS_SVH

// Address and data widths
`define ROM_ADDR_W      22
`define DL_ADDR_W       25
`define DATA_W          8

// Copier header placed in front of some images
`define CART_HDR_BYTES  512

// Cheat storage
`define CHEAT_SLOTS     4
`define CHEAT_REC_BYTES 16

`endif

//--- hw/cart_pkg.sv
`include "cart_params.svh"

package cart_pkg;

	// What the host means by a download index
	typedef enum logic [1:0] {
		DL_CART_SMS,
		DL_CART_GG,
		DL_CHEAT
	} dl_kind_e;

	// ROM write toggle handshake
	typedef enum logic {
		WR_IDLE,
		WR_WAIT    // Request toggled, ack not yet equal
	} wr_state_e;

	// Byte address into external ROM memory
	typedef logic [`ROM_ADDR_W-1:0] rom_addr_t;

endpackage

//--- hw/cheat_pkg.sv
`include "cart_params.svh"

package cheat_pkg;

	// Flags bit that turns on the compare against the ROM byte
	localparam int CHEAT_CMP_BIT = 0;

	// One downloaded record, each field little endian on the wire
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;   // Low byte used on the 8-bit bus
		logic [31:0] replace;   // Low byte used on the 8-bit bus
	} cheat_code_t;

	// Per-slot result for the read at the data stage
	typedef struct packed {
		logic              hit;
		logic [`DATA_W-1:0] replace;
	} cheat_hit_t;

	typedef logic [$clog2(`CHEAT_SLOTS)-1:0] slot_idx_t;

endpackage

//--- hw/cart_ifs.sv
`include "cart_params.svh"

// Slot writes from the cheat loader
interface cheat_wr_if import cheat_pkg::*; ();
	logic        wr;
	slot_idx_t   idx;
	cheat_code_t code;
	logic        clr;    // Empties every slot

	modport source (output wr, idx, code, clr);
	modport sink   (input wr, idx, code, clr);
endinterface

// Read at the address stage, between E0 and E1
interface rd_req_if;
	logic                   valid;
	logic [`ROM_ADDR_W-1:0] cpu_addr;
	logic [`ROM_ADDR_W-1:0] rom_addr;   // After mask and header offset

	modport source     (output valid, cpu_addr, rom_addr);
	modport slot_sink  (input valid, cpu_addr);
	modport valid_sink (input valid);
endinterface

// Data stage, between E1 and E2
interface slot_hit_if import cheat_pkg::*; ();
	cheat_hit_t         hit [`CHEAT_SLOTS];
	logic [`DATA_W-1:0] rdata;
	logic               rvalid;

	modport slot        (output hit, input rdata);
	modport data_source (output rdata, rvalid);
	modport sink        (input hit, rdata, rvalid);
endinterface

// Image geometry and cheat byte strobe from the download side
interface cart_cfg_if;
	logic [`ROM_ADDR_W-1:0] size_mask;
	logic [`ROM_ADDR_W-1:0] hdr_mask;
	logic                   hdr_present;
	logic                   cheat_wr;

	modport source     (output size_mask, hdr_mask, hdr_present, cheat_wr);
	modport map_sink   (input size_mask, hdr_mask, hdr_present);
	modport cheat_sink (input cheat_wr);
endinterface

//--- hw/cart_loader.sv
`include "cart_params.svh"

module cart_loader import cart_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic                  dl_wr,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [`DATA_W-1:0]    dl_data,
	input  logic                  rom_wr_ack,
	output logic                  dl_wait,
	output logic                  rom_wr_req,
	output rom_addr_t             rom_waddr,
	output logic [`DATA_W-1:0]    rom_wdata,
	output logic                  is_gg,
	cart_cfg_if.source            cfg
);

	localparam int HDR_BIT = $clog2(`CART_HDR_BYTES);   // Set when size is odd multiple of 512

	dl_kind_e  dl_kind;
	wr_state_e state;
	logic      cart_dl, cart_dl_q;
	logic      cart_wr;
	logic      wr_done;
	rom_addr_t dl_end;    // Bytes seen so far
	rom_addr_t dl_rom_addr;

	// Index decode
	always_comb begin
		if (&dl_index)
			dl_kind = DL_CHEAT;
		else if (dl_index[4:0] == 5'd2)
			dl_kind = DL_CART_GG;
		else
			dl_kind = DL_CART_SMS;
	end

	assign cart_dl      = dl_active && (dl_kind != DL_CHEAT);
	assign cart_wr      = dl_wr && cart_dl;
	assign cfg.cheat_wr = dl_wr && dl_active && (dl_kind == DL_CHEAT);
	assign dl_rom_addr  = dl_addr[`ROM_ADDR_W-1:0];

	assign dl_wait = (state == WR_WAIT);
	assign wr_done = (state == WR_WAIT) && (rom_wr_ack == rom_wr_req);

	// ====================================================================
	// ROM write handshake
	// ====================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state           <= WR_IDLE;
			rom_wr_req      <= 1'b0;
			rom_waddr       <= '0;
			cart_dl_q       <= 1'b0;
			is_gg           <= 1'b0;
			cfg.hdr_present <= 1'b0;
		end else begin
			cart_dl_q <= cart_dl;

			if (cart_dl && !cart_dl_q)
				rom_waddr <= '0;             // New image starts at 0
			else if (wr_done)
				rom_waddr <= rom_waddr + 1'b1;

			case (state)
				WR_IDLE: begin
					if (cart_wr) begin
						state      <= WR_WAIT;
						rom_wr_req <= ~rom_wr_req;
					end
				end
				WR_WAIT: begin
					if (rom_wr_ack == rom_wr_req)
						state <= WR_IDLE;
				end
				default: state <= WR_IDLE;
			endcase

			if (cart_wr)
				is_gg <= (dl_kind == DL_CART_GG);
			if (cart_dl_q && !cart_dl)
				cfg.hdr_present <= dl_end[HDR_BIT];
		end
	end

	// ====================================================================
	// Write data, size mask and header mask
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr && state == WR_IDLE)
			rom_wdata <= dl_data;
		if (cart_wr) begin
			dl_end <= dl_rom_addr + 1'b1;
			if (dl_addr == '0)
				cfg.size_mask <= '0;
			else
				cfg.size_mask <= cfg.size_mask | dl_rom_addr;
			// Header mask only covers the image behind the copier header
			if (dl_addr == `DL_ADDR_W'(`CART_HDR_BYTES))
				cfg.hdr_mask <= '0;
			else if (dl_addr > `DL_ADDR_W'(`CART_HDR_BYTES))
				cfg.hdr_mask <= cfg.hdr_mask
					| (dl_rom_addr - `ROM_ADDR_W'(`CART_HDR_BYTES));
		end
	end

endmodule

//--- hw/cheat_loader.sv
`include "cart_params.svh"

module cheat_loader import cheat_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [`DATA_W-1:0]    dl_data,
	cart_cfg_if.cheat_sink        cfg,
	cheat_wr_if.source            cw
);

	localparam int BYTE_W = $clog2(`CHEAT_REC_BYTES);
	localparam int PTR_W  = $clog2(`CHEAT_SLOTS + 1);

	cheat_code_t       rec;
	logic [BYTE_W-1:0] byte_sel;
	logic [1:0]        lane;
	logic              commit_q;
	logic              clr_q;
	logic [PTR_W-1:0]  ptr;     // Next free slot, stops at CHEAT_SLOTS
	logic              full;

	assign byte_sel = dl_addr[BYTE_W-1:0];
	assign lane     = byte_sel[1:0];
	assign full     = (ptr == PTR_W'(`CHEAT_SLOTS));

	// Record assembly, four bytes per field
	always_ff @(posedge clk_sys) begin
		if (cfg.cheat_wr) begin
			case (byte_sel[3:2])
				2'd0: rec.flags[lane*`DATA_W +: `DATA_W]   <= dl_data;
				2'd1: rec.address[lane*`DATA_W +: `DATA_W] <= dl_data;
				2'd2: rec.compare[lane*`DATA_W +: `DATA_W] <= dl_data;
				default: rec.replace[lane*`DATA_W +: `DATA_W] <= dl_data;
			endcase
		end
	end

	// ====================================================================
	// Slot pointer and strobes
	// ====================================================================
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			commit_q <= 1'b0;
			clr_q    <= 1'b0;
			ptr      <= '0;
		end else begin
			commit_q <= cfg.cheat_wr && (byte_sel == BYTE_W'(`CHEAT_REC_BYTES - 1));
			clr_q    <= cfg.cheat_wr && (dl_addr == '0);
			if (clr_q)
				ptr <= '0;
			else if (commit_q && !full)
				ptr <= ptr + 1'b1;
		end
	end

	assign cw.wr   = commit_q && !full;   // Extra records dropped
	assign cw.idx  = slot_idx_t'(ptr);
	assign cw.code = rec;
	assign cw.clr  = clr_q;

endmodule

//--- hw/cheat_slot.sv
`include "cart_params.svh"

module cheat_slot import cheat_pkg::*; #(
	parameter int IDX = 0
) (
	input  logic         clk_sys,
	input  logic         rst_n,
	cheat_wr_if.sink     cw,
	rd_req_if.slot_sink  rd,
	slot_hit_if.slot     sh,
	output logic         valid
);

	cheat_code_t code;
	logic        addr_hit_q;   // Address matched, read now at data stage
	logic        cmp_ok;

	// Stored code
	always_ff @(posedge clk_sys) begin
		if (cw.wr && cw.idx == slot_idx_t'(IDX))
			code <= cw.code;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			valid      <= 1'b0;
			addr_hit_q <= 1'b0;
		end else begin
			if (cw.clr)
				valid <= 1'b0;
			else if (cw.wr && cw.idx == slot_idx_t'(IDX))
				valid <= 1'b1;
			// E1
			addr_hit_q <= valid && rd.valid && (code.address == 32'(rd.cpu_addr));
		end
	end

	// E2, compare only when enabled in the flags
	assign cmp_ok = !code.flags[CHEAT_CMP_BIT] || (code.compare[`DATA_W-1:0] == sh.rdata);

	assign sh.hit[IDX].hit     = addr_hit_q && cmp_ok;
	assign sh.hit[IDX].replace = code.replace[`DATA_W-1:0];

endmodule

//--- hw/cheat_patch.sv
`include "cart_params.svh"

module cheat_patch import cheat_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               cheat_en,
	slot_hit_if.sink           sh,
	rd_req_if.valid_sink       rd,
	output logic [`DATA_W-1:0] cpu_rdata,
	output logic               cpu_rvalid
);

	logic               en_q;    // Enable as seen by the read at data stage
	logic               sel_hit;
	logic [`DATA_W-1:0] sel_byte;

	// Lowest numbered slot wins, so scan down
	always_comb begin
		sel_hit  = 1'b0;
		sel_byte = '0;
		for (int i = `CHEAT_SLOTS - 1; i >= 0; i--) begin
			if (sh.hit[i].hit) begin
				sel_hit  = 1'b1;
				sel_byte = sh.hit[i].replace;
			end
		end
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			en_q       <= 1'b0;
			cpu_rvalid <= 1'b0;
		end else begin
			if (rd.valid)
				en_q <= cheat_en;   // Taken at E1 with the address stage
			cpu_rvalid <= sh.rvalid;
		end
	end

	// Data out at E2
	always_ff @(posedge clk_sys) begin
		cpu_rdata <= (en_q && sel_hit) ? sel_byte : sh.rdata;
	end

endmodule

//--- hw/rom_read_path.sv
`include "cart_params.svh"

module rom_read_path import cart_pkg::*; (
	input  logic               clk_sys,
	input  logic               rst_n,
	input  logic               cpu_rd,
	input  rom_addr_t          cpu_addr,
	input  logic [`DATA_W-1:0] rom_rdata,
	output logic               rom_rd,
	output rom_addr_t          rom_raddr,
	cart_cfg_if.map_sink       cfg,
	rd_req_if.source           rd,
	slot_hit_if.data_source    sh
);

	rom_addr_t map_addr;

	// ====================================================================
	// Address mapping
	// ====================================================================
	always_comb begin
		if (cfg.hdr_present)
			map_addr = (cpu_addr + `ROM_ADDR_W'(`CART_HDR_BYTES)) & cfg.hdr_mask;   // Skip header
		else
			map_addr = cpu_addr & cfg.size_mask;   // Mirror small images
	end

	// Valid pipe, E0 then E1
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rd.valid  <= 1'b0;
			sh.rvalid <= 1'b0;
		end else begin
			rd.valid  <= cpu_rd;
			sh.rvalid <= rd.valid;   // Lines up with rom_rdata
		end
	end

	always_ff @(posedge clk_sys) begin
		rd.cpu_addr <= cpu_addr;
		rd.rom_addr <= map_addr;
	end

	assign rom_rd    = rd.valid;
	assign rom_raddr = rd.rom_addr;
	assign sh.rdata  = rom_rdata;

endmodule

//--- hw/cart_rom_top.sv
`include "cart_params.svh"

module cart_rom_top import cart_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	// Download
	input  logic                  dl_active,
	input  logic [7:0]            dl_index,
	input  logic                  dl_wr,
	input  logic [`DL_ADDR_W-1:0] dl_addr,
	input  logic [`DATA_W-1:0]    dl_data,
	output logic                  dl_wait,
	// ROM write
	output logic                  rom_wr_req,
	input  logic                  rom_wr_ack,
	output rom_addr_t             rom_waddr,
	output logic [`DATA_W-1:0]    rom_wdata,
	// ROM read
	output logic                  rom_rd,
	output rom_addr_t             rom_raddr,
	input  logic [`DATA_W-1:0]    rom_rdata,
	// CPU
	input  logic                  cpu_rd,
	input  rom_addr_t             cpu_addr,
	output logic [`DATA_W-1:0]    cpu_rdata,
	output logic                  cpu_rvalid,
	// Status
	input  logic                  cheat_en,
	output logic                  cheat_avail,
	output logic                  is_gg
);

	cart_cfg_if cfg ();
	cheat_wr_if cw ();
	rd_req_if   rd ();
	slot_hit_if sh ();

	logic [`CHEAT_SLOTS-1:0] slot_valid;

	cart_loader u_cart_loader (
		.clk_sys, .rst_n, .dl_active, .dl_index, .dl_wr, .dl_addr, .dl_data,
		.rom_wr_ack, .dl_wait, .rom_wr_req, .rom_waddr, .rom_wdata, .is_gg,
		.cfg(cfg.source)
	);

	cheat_loader u_cheat_loader (
		.clk_sys, .rst_n, .dl_addr, .dl_data,
		.cfg(cfg.cheat_sink), .cw(cw.source)
	);

	rom_read_path u_read_path (
		.clk_sys, .rst_n, .cpu_rd, .cpu_addr, .rom_rdata, .rom_rd, .rom_raddr,
		.cfg(cfg.map_sink), .rd(rd.source), .sh(sh.data_source)
	);

	// One slot per cheat
	for (genvar i = 0; i < `CHEAT_SLOTS; i++) begin : g_slot
		cheat_slot #(.IDX(i)) u_slot (
			.clk_sys, .rst_n, .cw(cw.sink), .rd(rd.slot_sink), .sh(sh.slot),
			.valid(slot_valid[i])
		);
	end

	cheat_patch u_patch (
		.clk_sys, .rst_n, .cheat_en, .sh(sh.sink), .rd(rd.valid_sink),
		.cpu_rdata, .cpu_rvalid
	);

	assign cheat_avail = |slot_valid;

endmodule

//--- dv/tb_top.sv
`include "cart_params.svh"

module tb_top;

	logic                   clk_sys;
	logic                   rst_n;
	logic                   dl_active;
	logic [7:0]             dl_index;
	logic                   dl_wr;
	logic [`DL_ADDR_W-1:0]  dl_addr;
	logic [`DATA_W-1:0]     dl_data;
	logic                   dl_wait;
	logic                   rom_wr_req;
	logic                   rom_wr_ack;
	logic [`ROM_ADDR_W-1:0] rom_waddr;
	logic [`DATA_W-1:0]     rom_wdata;
	logic                   rom_rd;
	logic [`ROM_ADDR_W-1:0] rom_raddr;
	logic [`DATA_W-1:0]     rom_rdata;
	logic                   cpu_rd;
	logic [`ROM_ADDR_W-1:0] cpu_addr;
	logic [`DATA_W-1:0]     cpu_rdata;
	logic                   cpu_rvalid;
	logic                   cheat_en;
	logic                   cheat_avail;
	logic                   is_gg;

	logic [7:0]   image [4096];    // Bytes as downloaded
	logic [7:0]   mem   [4096];    // External ROM
	logic [7:0]   exp_q [$];       // Expected read data in issue order
	logic [7:0]   exp_b;
	logic [127:0] slot_rec [`CHEAT_SLOTS];
	int           slot_cnt;
	int unsigned  size_mask_m, hdr_mask_m;
	logic         hdr_m;
	int unsigned  ack_delay, wr_count, cart_bytes, req_toggles;
	logic         req_prev = 1'b0;
	logic         rd_pend = 1'b0;
	logic [`ROM_ADDR_W-1:0] rd_addr_q;
	logic [2:0]   rd_sh;

	cart_rom_top dut0 (.*);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	task automatic stop_run();
		$display("Simulation failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic mismatch(string msg);
		$display("[FAIL] %0t: %s", $time, msg);
		stop_run();
	endtask

	task automatic timed_out(string what);
		$display("Gave up at %0t waiting for %s", $time, what);
		stop_run();
	endtask

	// ====================================================================
	// Memory model
	// ====================================================================
	initial begin
		rom_wr_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (rst_n && rom_wr_req != rom_wr_ack) begin
				assert (rom_waddr == wr_count)
					else mismatch($sformatf("rom_waddr %0d, expected %0d", rom_waddr, wr_count));
				mem[rom_waddr[11:0]] = rom_wdata;
				wr_count++;
				repeat (ack_delay) @(negedge clk_sys);
				rom_wr_ack = rom_wr_req;   // Answer the toggle
			end
		end
	end

	// Read data one falling edge after rom_rd was seen, counts request toggles
	always @(negedge clk_sys) begin
		if (rom_wr_req != req_prev)
			req_toggles++;
		req_prev = rom_wr_req;
		if (rd_pend)
			rom_rdata = mem[rd_addr_q[11:0]];
		rd_pend   = rom_rd;
		rd_addr_q = rom_raddr;
	end

	// ====================================================================
	// Read response checks
	// ====================================================================
	always @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			rd_sh <= '0;
		else
			rd_sh <= {rd_sh[1:0], cpu_rd};
	end

	assert property (@(negedge clk_sys) disable iff (!rst_n) cpu_rvalid == rd_sh[2])
		else mismatch("cpu_rvalid not two cycles after cpu_rd");

	always @(negedge clk_sys) begin
		if (rst_n && cpu_rvalid && exp_q.size() != 0) begin
			exp_b = exp_q.pop_front();
			assert (cpu_rdata == exp_b)
				else mismatch($sformatf("cpu_rdata %02h, expected %02h", cpu_rdata, exp_b));
		end
	end

	// Unpatched byte after mask and header offset
	function automatic logic [7:0] rom_byte(int unsigned a);
		int unsigned ra;
		ra = hdr_m ? ((a + 512) & hdr_mask_m) : (a & size_mask_m);
		return image[ra];
	endfunction

	function automatic logic [7:0] expected_read(int unsigned a);
		logic [7:0] rb;
		logic [7:0] res;
		logic       found;
		rb    = rom_byte(a);
		res   = rb;
		found = 1'b0;
		for (int i = 0; i < slot_cnt; i++) begin
			if (cheat_en && !found && slot_rec[i][63:32] == a
					&& (!slot_rec[i][0] || slot_rec[i][71:64] == rb)) begin
				found = 1'b1;
				res   = slot_rec[i][103:96];   // Lowest slot wins
			end
		end
		return res;
	endfunction

	task automatic write_byte(int unsigned addr, logic [7:0] data);
		int n;
		n       = 0;
		dl_wr   = 1'b1;
		dl_addr = `DL_ADDR_W'(addr);
		dl_data = data;
		@(negedge clk_sys);
		dl_wr = 1'b0;
		while (dl_wait) begin
			n++;
			if (n > 40)
				timed_out("dl_wait to drop");
			@(negedge clk_sys);
		end
	endtask

	task automatic download_cart(int unsigned len, logic [7:0] index);
		dl_index    = index;
		dl_active   = 1'b1;
		wr_count    = 0;
		size_mask_m = 0;
		hdr_mask_m  = 0;
		@(negedge clk_sys);
		for (int unsigned a = 0; a < len; a++) begin
			image[a]    = 8'($urandom());
			ack_delay   = $urandom_range(5, 0);
			size_mask_m = size_mask_m | a;
			if (a >= 512)
				hdr_mask_m = hdr_mask_m | (a - 512);
			cart_bytes++;
			write_byte(a, image[a]);
			assert (req_toggles == cart_bytes)
				else mismatch($sformatf("%0d request toggles for %0d bytes", req_toggles, cart_bytes));
		end
		dl_active = 1'b0;
		hdr_m     = len[9];   // Odd multiple of 512 means copier header
		@(negedge clk_sys);
		for (int unsigned a = 0; a < len; a++)
			assert (mem[a] == image[a])
				else mismatch($sformatf("ROM byte %0d is %02h, expected %02h", a, mem[a], image[a]));
		assert (is_gg == (index[4:0] == 5'd2)) else mismatch("is_gg does not follow dl_index");
	endtask

	task automatic drain_reads();
		int n;
		n = 0;
		while (exp_q.size() != 0) begin
			n++;
			if (n > 10)
				timed_out("read data");
			@(negedge clk_sys);
		end
	endtask

	// Leaves cpu_rd high so the next read can follow back to back
	task automatic issue_read(int unsigned a);
		cpu_rd   = 1'b1;
		cpu_addr = `ROM_ADDR_W'(a);
		exp_q.push_back(expected_read(a));
		@(negedge clk_sys);
	endtask

	task automatic read_once(int unsigned a);
		issue_read(a);
		cpu_rd = 1'b0;
		drain_reads();
	endtask

	task automatic random_reads(int count);
		for (int i = 0; i < count; i++) begin
			issue_read($urandom() & 32'h3fffff);
			if ($urandom_range(1, 0) == 1) begin
				cpu_rd = 1'b0;
				@(negedge clk_sys);
			end
		end
		cpu_rd = 1'b0;
		drain_reads();
	endtask

	task automatic send_cheat(int unsigned base, logic [31:0] flags, logic [31:0] addr,
			logic [31:0] cmp, logic [31:0] rep);
		logic [127:0] rec;
		int           n;
		rec = {rep, cmp, addr, flags};
		n   = 0;
		if (base == 0)
			slot_cnt = 0;   // Record at 0 empties every slot
		for (int b = 0; b < 16; b++) begin
			if (b == 15 && base == 0)
				assert (!cheat_avail) else mismatch("cheat_avail high after clear");
			write_byte(base + b, rec[8*b +: 8]);
		end
		if (slot_cnt < `CHEAT_SLOTS) begin
			slot_rec[slot_cnt] = rec;
			slot_cnt++;
		end
		while (!cheat_avail) begin
			n++;
			if (n > 10)
				timed_out("cheat_avail");
			@(negedge clk_sys);
		end
	endtask

	// ====================================================================
	// Stimulus
	// ====================================================================
	initial begin
		void'($urandom(72542));
		rst_n       = 1'b0;
		dl_active   = 1'b0;
		dl_index    = 8'h00;
		dl_wr       = 1'b0;
		dl_addr     = '0;
		dl_data     = '0;
		rom_rdata   = '0;
		cpu_rd      = 1'b0;
		cpu_addr    = '0;
		cheat_en    = 1'b0;
		slot_cnt    = 0;
		cart_bytes  = 0;
		req_toggles = 0;
		ack_delay   = 0;
		repeat (4) @(negedge clk_sys);
		rst_n = 1'b1;
		assert (!dl_wait && !rom_wr_req && !rom_rd && !cpu_rvalid && !cheat_avail)
			else mismatch("outputs not low after reset");

		download_cart(2048, 8'h01);   // Mirrored every 2048 bytes
		random_reads(60);
		download_cart(2560, 8'h02);   // Game Gear image behind a copier header
		random_reads(60);

		dl_index  = 8'hff;
		dl_active = 1'b1;
		@(negedge clk_sys);
		send_cheat(0, 0, 32'h100, 0, {24'h0, ~rom_byte(32'h100)});
		cheat_en = 1'b1;
		read_once(32'h100);
		cheat_en = 1'b0;
		read_once(32'h100);
		dl_active = 1'b0;
		@(negedge clk_sys);

		// Fresh set, fifth record has no free slot
		dl_active = 1'b1;
		@(negedge clk_sys);
		send_cheat(0, 1, 32'h200, {24'h0, ~rom_byte(32'h200)}, 32'h11);
		send_cheat(16, 0, 32'h300, 0, {24'h0, ~rom_byte(32'h300)});
		send_cheat(32, 0, 32'h300, 0, {24'h0, rom_byte(32'h300) ^ 8'h0f});
		send_cheat(48, 1, 32'h340, {24'h0, rom_byte(32'h340)}, {24'h0, ~rom_byte(32'h340)});
		send_cheat(64, 0, 32'h380, 0, {24'h0, ~rom_byte(32'h380)});
		dl_active = 1'b0;
		cheat_en  = 1'b1;
		@(negedge clk_sys);
		read_once(32'h200);
		read_once(32'h300);
		read_once(32'h340);
		read_once(32'h380);
		random_reads(40);

		$display("Simulation passed");
		$finish;
	end

endmodule

//--- tb.f
+incdir+hw
hw/cart_pkg.sv
hw/cheat_pkg.sv
hw/cart_ifs.sv
hw/cart_loader.sv
hw/cheat_loader.sv
hw/cheat_slot.sv
hw/cheat_patch.sv
hw/rom_read_path.sv
hw/cart_rom_top.sv
dv/tb_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --assert --top-module tb_top -f tb.f
	@out=$$(./obj_dir/Vtb_top); echo "$$out"; echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
